// ==== verilog/bru_pkg.sv ====
/*
 * Shared widths, op codes and stage payloads of the branch resolution unit.
 * Physical register and ROB index widths are fixed here, so every user of the
 * structs must agree on them. Bit 3 of an op code marks a conditional branch.
 */
package bru_pkg;

    localparam int XLEN            = 32;
    localparam int LOG_PR_COUNT    = 7;
    localparam int LOG_ROB_ENTRIES = 7;

    typedef enum logic [3:0] {
        BRU_JALR  = 4'b0000,
        BRU_JAL   = 4'b0001,
        BRU_AUIPC = 4'b0100,
        BRU_BEQ   = 4'b1000,
        BRU_BNE   = 4'b1001,
        BRU_BLT   = 4'b1100,
        BRU_BGE   = 4'b1101,
        BRU_BLTU  = 4'b1110,
        BRU_BGEU  = 4'b1111
    } bru_op_e;

    // Same op word seen as an op code or as branch condition fields
    typedef union packed {
        bru_op_e code;
        struct packed {
            logic is_branch;
            logic is_less;
            logic is_unsigned;
            logic invert;
        } br;
    } bru_op_u;

    // ------------------------------------------------------------------------
    // Stage payloads

    typedef struct packed {
        bru_op_u                    op;
        logic [XLEN-1:0]            pc;
        logic [XLEN-1:0]            pred_next_pc;
        logic [XLEN-1:0]            imm;
        logic                       a_unneeded;
        logic                       b_unneeded;
        logic [LOG_PR_COUNT-1:0]    dest_pr;
        logic [LOG_ROB_ENTRIES-1:0] rob_index;
    } bru_issue_t;

    typedef struct packed {
        bru_op_u                    op;
        logic [XLEN-1:0]            pc;
        logic [XLEN-1:0]            pred_next_pc;
        logic [XLEN-1:0]            imm;
        logic [XLEN-1:0]            a;
        logic [XLEN-1:0]            b;
        logic [LOG_PR_COUNT-1:0]    dest_pr;
        logic [LOG_ROB_ENTRIES-1:0] rob_index;
    } bru_ex_t;

    typedef struct packed {
        logic [XLEN-1:0]            data;
        logic [LOG_PR_COUNT-1:0]    pr;
        logic [LOG_ROB_ENTRIES-1:0] rob_index;
    } bru_wb_t;

    typedef struct packed {
        logic                       mispredict;
        logic [LOG_ROB_ENTRIES-1:0] rob_index;
        logic [XLEN-1:0]            pc;
        logic                       taken;
    } bru_restart_t;

endpackage

// ==== verilog/bru_operand_collect.sv ====
/*
 * Operand collection stage. Holds one issued op until both sources are present.
 * An operand is taken from read_data at the op's bank and the acked port in the
 * cycle of its ack, or from the saved copy after that. Bank indices must be
 * below NUM_BANKS whenever an ack arrives.
 */
`timescale 1ns/100ps

module bru_operand_collect #(
    parameter int  NUM_BANKS = 4,
    localparam int BANK_W    = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1
) (
    input  logic                                       CLK,
    input  logic                                       nRST,
    input  logic                                       issue_valid,
    input  bru_pkg::bru_issue_t                        issue,
    input  logic [BANK_W-1:0]                          issue_a_bank,
    input  logic [BANK_W-1:0]                          issue_b_bank,
    input  logic                                       a_read_ack,
    input  logic                                       a_read_port,
    input  logic                                       b_read_ack,
    input  logic                                       b_read_port,
    input  logic [NUM_BANKS-1:0][1:0][bru_pkg::XLEN-1:0] read_data,
    input  logic                                       ex_hold,
    output logic                                       issue_ready,
    output logic                                       launch_valid,
    output bru_pkg::bru_ex_t                           launch
);
    import bru_pkg::*;

    logic              oc_valid;
    bru_issue_t        oc_op;
    logic [BANK_W-1:0] a_bank;
    logic [BANK_W-1:0] b_bank;
    logic              a_saved;
    logic              b_saved;
    logic [XLEN-1:0]   a_saved_data;
    logic [XLEN-1:0]   b_saved_data;
    logic [XLEN-1:0]   a_value;
    logic [XLEN-1:0]   b_value;
    logic              a_present;
    logic              b_present;
    logic              accept;

    assign accept = issue_valid & issue_ready;

    // ------------------------------------------------------------------------
    // Entry state

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            oc_valid <= 1'b0;
            a_saved  <= 1'b0;
            b_saved  <= 1'b0;
        end else if (accept) begin
            oc_valid <= 1'b1;
            a_saved  <= 1'b0;
            b_saved  <= 1'b0;
        end else if (launch_valid) begin
            oc_valid <= 1'b0;
        end else begin
            // Remember operands that arrived while the other is still missing
            a_saved <= a_saved | (oc_valid & a_read_ack);
            b_saved <= b_saved | (oc_valid & b_read_ack);
        end
    end

    // Saved copies follow the selected value, so they latch the bus on the ack
    always_ff @(posedge CLK) begin
        if (accept) begin
            oc_op  <= issue;
            a_bank <= issue_a_bank;
            b_bank <= issue_b_bank;
        end
        a_saved_data <= a_value;
        b_saved_data <= b_value;
    end

    // ------------------------------------------------------------------------
    // Operand select and launch

    assign a_value = a_saved ? a_saved_data : read_data[a_bank][a_read_port];
    assign b_value = b_saved ? b_saved_data : read_data[b_bank][b_read_port];

    assign a_present = oc_op.a_unneeded | a_saved | a_read_ack;
    assign b_present = oc_op.b_unneeded | b_saved | b_read_ack;

    assign launch_valid = oc_valid & ~ex_hold & a_present & b_present;
    assign issue_ready  = ~oc_valid | launch_valid;

    always_comb begin
        launch.op           = oc_op.op;
        launch.pc           = oc_op.pc;
        launch.pred_next_pc = oc_op.pred_next_pc;
        launch.imm          = oc_op.imm;
        launch.a            = a_value;
        launch.b            = b_value;
        launch.dest_pr      = oc_op.dest_pr;
        launch.rob_index    = oc_op.rob_index;
    end

    // Bank index is set at issue, the ack comes later from the PRF
    a_bank_in_range: assert property (@(posedge CLK) disable iff (!nRST)
        (oc_valid && a_read_ack && !a_saved && !oc_op.a_unneeded) |-> (a_bank < NUM_BANKS));

    b_bank_in_range: assert property (@(posedge CLK) disable iff (!nRST)
        (oc_valid && b_read_ack && !b_saved && !oc_op.b_unneeded) |-> (b_bank < NUM_BANKS));

endmodule

// ==== verilog/bru_execute.sv ====
/*
 * Execute stage. One cycle from launch to the next writeback and restart values.
 * The EX register freezes while the result register is held. Branch conditions
 * come from the op field view; jumps and AUIPC are decoded by op code.
 */
`timescale 1ns/100ps

module bru_execute (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  launch_valid,
    input  bru_pkg::bru_ex_t      launch,
    input  logic                  wb_hold,
    output logic                  ex_hold,
    output logic                  next_wb_valid,
    output bru_pkg::bru_wb_t      next_wb,
    output logic                  next_restart_valid,
    output bru_pkg::bru_restart_t next_restart
);
    import bru_pkg::*;

    logic            ex_valid;
    bru_ex_t         ex_q;
    logic [XLEN-1:0] pc_plus_4;
    logic [XLEN-1:0] pc_plus_imm;
    logic [XLEN-1:0] a_plus_imm;
    logic            a_eq_b;
    logic            a_lt_b;
    logic            br_taken;
    logic [XLEN-1:0] wb_data;
    logic [XLEN-1:0] restart_pc;
    logic            restart_taken;

    assign ex_hold = ex_valid & wb_hold;

    // ------------------------------------------------------------------------
    // EX register

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ex_valid <= 1'b0;
        end else if (!ex_hold) begin
            ex_valid <= launch_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (!ex_hold) begin
            ex_q <= launch;
        end
    end

    // ------------------------------------------------------------------------
    // Targets and branch condition

    assign pc_plus_4   = ex_q.pc + XLEN'(4);
    assign pc_plus_imm = ex_q.pc + ex_q.imm;
    assign a_plus_imm  = ex_q.a + ex_q.imm;

    assign a_eq_b = (ex_q.a == ex_q.b);
    assign a_lt_b = ex_q.op.br.is_unsigned ? (ex_q.a < ex_q.b)
                                           : ($signed(ex_q.a) < $signed(ex_q.b));

    // BNE, BGE and BGEU are the inverted forms of BEQ, BLT and BLTU
    assign br_taken = (ex_q.op.br.is_less ? a_lt_b : a_eq_b) ^ ex_q.op.br.invert;

    always_comb begin
        next_wb_valid      = 1'b0;
        next_restart_valid = 1'b0;
        wb_data            = pc_plus_4;
        restart_pc         = pc_plus_imm;
        restart_taken      = 1'b1;
        case (ex_q.op.code)
            BRU_JALR: begin
                next_wb_valid      = ex_valid;
                next_restart_valid = ex_valid;
                restart_pc         = a_plus_imm;
            end
            BRU_JAL: begin
                next_wb_valid      = ex_valid;
                next_restart_valid = ex_valid;
            end
            BRU_AUIPC: begin
                next_wb_valid = ex_valid;
                wb_data       = pc_plus_imm;
            end
            BRU_BEQ, BRU_BNE, BRU_BLT, BRU_BGE, BRU_BLTU, BRU_BGEU: begin
                next_restart_valid = ex_valid;
                restart_taken      = br_taken;
                restart_pc         = br_taken ? pc_plus_imm : pc_plus_4;
            end
            default: begin
                // Unknown op retires silently
                next_wb_valid      = 1'b0;
                next_restart_valid = 1'b0;
            end
        endcase
    end

    assign next_wb = '{data: wb_data, pr: ex_q.dest_pr, rob_index: ex_q.rob_index};

    assign next_restart = '{mispredict: (ex_q.pred_next_pc != restart_pc),
                            rob_index:  ex_q.rob_index,
                            pc:         restart_pc,
                            taken:      restart_taken};

    unknown_op_quiet: assert property (@(posedge CLK) disable iff (!nRST)
        (ex_valid && !(ex_q.op.code inside {BRU_JALR, BRU_JAL, BRU_AUIPC, BRU_BEQ, BRU_BNE,
                                            BRU_BLT, BRU_BGE, BRU_BLTU, BRU_BGEU}))
        |-> !(next_wb_valid || next_restart_valid));

endmodule

// ==== verilog/bru_result_reg.sv ====
/*
 * Writeback and restart output register. Both outputs freeze together while a
 * writeback waits on wb_ready, so a held restart request repeats and the ROB
 * must tolerate the duplicates.
 */
`timescale 1ns/100ps

module bru_result_reg (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  next_wb_valid,
    input  bru_pkg::bru_wb_t      next_wb,
    input  logic                  next_restart_valid,
    input  bru_pkg::bru_restart_t next_restart,
    input  logic                  wb_ready,
    output logic                  wb_hold,
    output logic                  wb_valid,
    output bru_pkg::bru_wb_t      wb,
    output logic                  restart_valid,
    output bru_pkg::bru_restart_t restart
);

    // PRF back-pressure
    assign wb_hold = wb_valid & ~wb_ready;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wb_valid      <= 1'b0;
            restart_valid <= 1'b0;
        end else if (!wb_hold) begin
            wb_valid      <= next_wb_valid;
            restart_valid <= next_restart_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (!wb_hold) begin
            wb      <= next_wb;
            restart <= next_restart;
        end
    end

    // A held result must reach the PRF and ROB unchanged
    held_result_stable: assert property (@(posedge CLK) disable iff (!nRST)
        wb_hold |=> (wb_valid && $stable(wb) && $stable(restart) && $stable(restart_valid)));

endmodule

// ==== verilog/bru_pipeline.sv ====
/*
 * Branch resolution unit, three stages: operand collection, execute and the
 * writeback/restart register. Results leave in issue order, at least two edges
 * after the op is accepted. NUM_BANKS sets the PRF bank count.
 */
`timescale 1ns/100ps

module bru_pipeline #(
    parameter int  NUM_BANKS = 4,
    localparam int BANK_W    = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1
) (
    input  logic                                       CLK,
    input  logic                                       nRST,
    input  logic                                       issue_valid,
    input  bru_pkg::bru_issue_t                        issue,
    input  logic [BANK_W-1:0]                          issue_a_bank,
    input  logic [BANK_W-1:0]                          issue_b_bank,
    output logic                                       issue_ready,
    input  logic                                       a_read_ack,
    input  logic                                       a_read_port,
    input  logic                                       b_read_ack,
    input  logic                                       b_read_port,
    input  logic [NUM_BANKS-1:0][1:0][bru_pkg::XLEN-1:0] read_data,
    output logic                                       wb_valid,
    output bru_pkg::bru_wb_t                           wb,
    input  logic                                       wb_ready,
    output logic                                       restart_valid,
    output bru_pkg::bru_restart_t                      restart
);
    import bru_pkg::*;

    logic         launch_valid;
    bru_ex_t      launch;
    logic         ex_hold;
    logic         wb_hold;
    logic         next_wb_valid;
    bru_wb_t      next_wb;
    logic         next_restart_valid;
    bru_restart_t next_restart;

    bru_operand_collect #(
        .NUM_BANKS(NUM_BANKS)
    ) u_oc (
        .CLK          (CLK),
        .nRST         (nRST),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .issue_a_bank (issue_a_bank),
        .issue_b_bank (issue_b_bank),
        .a_read_ack   (a_read_ack),
        .a_read_port  (a_read_port),
        .b_read_ack   (b_read_ack),
        .b_read_port  (b_read_port),
        .read_data    (read_data),
        .ex_hold      (ex_hold),
        .issue_ready  (issue_ready),
        .launch_valid (launch_valid),
        .launch       (launch)
    );

    bru_execute u_ex (
        .CLK                (CLK),
        .nRST               (nRST),
        .launch_valid       (launch_valid),
        .launch             (launch),
        .wb_hold            (wb_hold),
        .ex_hold            (ex_hold),
        .next_wb_valid      (next_wb_valid),
        .next_wb            (next_wb),
        .next_restart_valid (next_restart_valid),
        .next_restart       (next_restart)
    );

    bru_result_reg u_wb (
        .CLK                (CLK),
        .nRST               (nRST),
        .next_wb_valid      (next_wb_valid),
        .next_wb            (next_wb),
        .next_restart_valid (next_restart_valid),
        .next_restart       (next_restart),
        .wb_ready           (wb_ready),
        .wb_hold            (wb_hold),
        .wb_valid           (wb_valid),
        .wb                 (wb),
        .restart_valid      (restart_valid),
        .restart            (restart)
    );

endmodule

// ==== include/bru_ref_model.svh ====
/*
 * Reference model and random source for the BRU testbench. Needs bru_pkg to be
 * compiled first. The model has no notion of timing; callers queue its results
 * in issue order. lfsr_bits takes at most 32 bits per call.
 */
`ifndef BRU_REF_MODEL_SVH
`define BRU_REF_MODEL_SVH

// Expected outcome of one issued op
typedef struct packed {
    logic                  wb_valid;
    bru_pkg::bru_wb_t      wb;
    logic                  restart_valid;
    bru_pkg::bru_restart_t restart;
} bru_expect_t;

localparam logic [15:0] LFSR_SEED = 16'd47608;

// Fibonacci form, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
endfunction

// One step per bit, LSB first
function automatic logic [31:0] lfsr_bits(ref logic [15:0] state, input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
        state   = lfsr_step(state);
        bits[i] = state[0];
    end
    return bits;
endfunction

function automatic bru_expect_t bru_expect(input bru_pkg::bru_issue_t op,
                                           input logic [bru_pkg::XLEN-1:0] a,
                                           input logic [bru_pkg::XLEN-1:0] b);
    bru_expect_t                e;
    logic [bru_pkg::XLEN-1:0] pc4;
    logic [bru_pkg::XLEN-1:0] pc_imm;
    logic                       is_br;
    logic                       taken;
    pc4    = op.pc + 32'd4;
    pc_imm = op.pc + op.imm;
    is_br  = 1'b1;
    taken  = 1'b0;
    e      = '{wb_valid: 1'b0, wb: '{data: pc4, pr: op.dest_pr, rob_index: op.rob_index},
               restart_valid: 1'b0,
               restart: '{mispredict: 1'b0, rob_index: op.rob_index, pc: pc_imm, taken: 1'b1}};
    case (op.op.code)
        bru_pkg::BRU_BEQ:  taken = (a == b);
        bru_pkg::BRU_BNE:  taken = (a != b);
        bru_pkg::BRU_BLT:  taken = ($signed(a) < $signed(b));
        bru_pkg::BRU_BGE:  taken = ($signed(a) >= $signed(b));
        bru_pkg::BRU_BLTU: taken = (a < b);
        bru_pkg::BRU_BGEU: taken = (a >= b);
        default:           is_br = 1'b0;
    endcase
    if (is_br) begin
        e.restart_valid = 1'b1;
        e.restart.taken = taken;
        e.restart.pc    = taken ? pc_imm : pc4;
    end else if (op.op.code == bru_pkg::BRU_AUIPC) begin
        e.wb_valid   = 1'b1;
        e.wb.data    = pc_imm;
    end else if (op.op.code inside {bru_pkg::BRU_JAL, bru_pkg::BRU_JALR}) begin
        e.wb_valid      = 1'b1;
        e.restart_valid = 1'b1;
        if (op.op.code == bru_pkg::BRU_JALR) begin
            e.restart.pc = a + op.imm;
        end
    end
    e.restart.mispredict = (op.pred_next_pc != e.restart.pc);
    return e;
endfunction

`endif

// ==== bench/tb_bru_pipeline.sv ====
/*
 * Testbench for bru_pipeline with four PRF banks. Ops, operand ack delays, read
 * data and wb_ready all come from one LFSR stream. Expected results are queued
 * when the op is accepted and compared in order at every retiring edge.
 */
`timescale 1ns/100ps

module tb_bru_pipeline;
    import bru_pkg::*;

    `include "bru_ref_model.svh"

    localparam int NUM_BANKS = 4;
    localparam int NUM_OPS   = 400;
    localparam int TIMEOUT   = 200;

    // Nine valid op codes followed by four unknown ones
    localparam logic [3:0] OP_TABLE [13] = '{4'h0, 4'h1, 4'h4, 4'h8, 4'h9, 4'hc, 4'hd,
                                             4'he, 4'hf, 4'h2, 4'h6, 4'ha, 4'hb};

    logic                                CLK;
    logic                                nRST;
    logic                                issue_valid;
    bru_issue_t                          issue;
    logic [1:0]                          issue_a_bank;
    logic [1:0]                          issue_b_bank;
    logic                                issue_ready;
    logic                                a_read_ack;
    logic                                a_read_port;
    logic                                b_read_ack;
    logic                                b_read_port;
    logic [NUM_BANKS-1:0][1:0][XLEN-1:0] read_data;
    logic                                wb_valid;
    bru_wb_t                             wb;
    logic                                wb_ready;
    logic                                restart_valid;
    bru_restart_t                        restart;

    bru_expect_t expect_q[$];
    int          value_errors;
    int          unexpected_results;
    int          checked;
    logic [15:0] rng;

    bru_pipeline #(
        .NUM_BANKS(NUM_BANKS)
    ) u_dut (.*);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // ------------------------------------------------------------------------
    // Compare tasks

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_wb(input bru_wb_t got, input bru_wb_t exp);
        if (got !== exp) begin
            $display("[FAIL] wb got %h expected %h", got, exp);
            value_errors++;
        end
    endtask

    task automatic check_restart(input bru_restart_t got, input bru_restart_t exp);
        if (got !== exp) begin
            $display("[FAIL] restart got %h expected %h", got, exp);
            value_errors++;
        end
    endtask

    // Random op with its operands and the model's expected outcome
    task automatic gen_op(output bru_issue_t op, output logic [XLEN-1:0] a,
                          output logic [XLEN-1:0] b, output bru_expect_t e);
        logic [31:0] r;
        int          idx;
        r     = lfsr_bits(rng, 5);
        idx   = (r < 27) ? r % 9 : 9 + (r - 27) % 4;
        op    = '0;
        op.op = bru_op_u'(OP_TABLE[idx]);
        r     = lfsr_bits(rng, 32);
        op.pc = {r[31:2], 2'b00};
        r      = lfsr_bits(rng, 13);
        op.imm = {{19{r[12]}}, r[12:1], 1'b0};
        r            = lfsr_bits(rng, 14);
        op.dest_pr   = r[6:0];
        op.rob_index = r[13:7];
        a = lfsr_bits(rng, 32);
        b = a;
        // Equal operands one time in four
        if (lfsr_bits(rng, 2) != 0) begin
            b = lfsr_bits(rng, 32);
        end
        case (op.op.code)
            BRU_JAL, BRU_AUIPC: {op.a_unneeded, op.b_unneeded} = 2'b11;
            BRU_JALR:           {op.a_unneeded, op.b_unneeded} = 2'b01;
            BRU_BEQ, BRU_BNE, BRU_BLT, BRU_BGE, BRU_BLTU, BRU_BGEU: begin
                {op.a_unneeded, op.b_unneeded} = 2'b00;
            end
            default:            {op.a_unneeded, op.b_unneeded} = 2'(lfsr_bits(rng, 2));
        endcase
        e = bru_expect(op, a, b);
        r = lfsr_bits(rng, 32);
        op.pred_next_pc = r[0] ? e.restart.pc : r;
        e = bru_expect(op, a, b);
    endtask

    // ------------------------------------------------------------------------
    // Stimulus: issue, operand acks, read data and wb_ready

    initial begin : drive
        bru_issue_t                          nxt_op;
        bru_expect_t                         nxt_exp;
        logic [XLEN-1:0]                     nxt_a;
        logic [XLEN-1:0]                     nxt_b;
        logic [XLEN-1:0]                     cur_a;
        logic [XLEN-1:0]                     cur_b;
        logic [1:0]                          cur_a_bank;
        logic [1:0]                          cur_b_bank;
        logic                                a_left;
        logic                                b_left;
        logic                                a_now;
        logic [2:0]                          a_dly;
        logic [2:0]                          b_dly;
        logic                                a_port;
        logic                                b_port;
        logic                                presenting;
        logic [NUM_BANKS-1:0][1:0][XLEN-1:0] rd;
        int                                  issued;
        int                                  accepted;
        int                                  idle;
        bit                                  timed_out;
        rng                = LFSR_SEED;
        value_errors       = 0;
        unexpected_results = 0;
        checked            = 0;
        nRST               = 1'b0;
        issue_valid        = 1'b0;
        issue              = '0;
        issue_a_bank       = '0;
        issue_b_bank       = '0;
        a_read_ack         = 1'b0;
        a_read_port        = 1'b0;
        b_read_ack         = 1'b0;
        b_read_port        = 1'b0;
        read_data          = '0;
        wb_ready           = 1'b1;
        a_left             = 1'b0;
        b_left             = 1'b0;
        presenting         = 1'b0;
        issued             = 0;
        accepted           = 0;
        idle               = 0;
        timed_out          = 1'b0;
        repeat (16) @(posedge CLK);
        nRST <= 1'b1;
        @(posedge CLK);
        check_flag("wb_valid", wb_valid, 1'b0);
        check_flag("restart_valid", restart_valid, 1'b0);
        check_flag("issue_ready", issue_ready, 1'b1);

        while ((accepted < NUM_OPS || a_left || b_left) && !timed_out) begin
            @(posedge CLK);
            // OC is full while an operand is still missing
            if ((a_left && !a_read_ack) || (b_left && !b_read_ack)) begin
                check_flag("issue_ready", issue_ready, 1'b0);
            end
            if (a_read_ack) begin
                a_left = 1'b0;
            end
            if (b_read_ack) begin
                b_left = 1'b0;
            end
            idle++;
            if (issue_valid && issue_ready) begin
                if (nxt_exp.wb_valid || nxt_exp.restart_valid) begin
                    expect_q.push_back(nxt_exp);
                end
                cur_a      = nxt_a;
                cur_b      = nxt_b;
                cur_a_bank = issue_a_bank;
                cur_b_bank = issue_b_bank;
                a_left     = !nxt_op.a_unneeded;
                b_left     = !nxt_op.b_unneeded;
                a_dly      = 3'(lfsr_bits(rng, 3));
                b_dly      = 3'(lfsr_bits(rng, 3));
                presenting = 1'b0;
                accepted++;
                idle = 0;
                issue_valid <= 1'b0;
            end
            if (idle > TIMEOUT) begin
                $display("timeout: no op accepted for %0d cycles", TIMEOUT);
                timed_out = 1'b1;
            end

            for (int i = 0; i < NUM_BANKS; i++) begin
                for (int p = 0; p < 2; p++) begin
                    rd[i][p] = lfsr_bits(rng, 32);
                end
            end
            a_port = 1'(lfsr_bits(rng, 1));
            b_port = 1'(lfsr_bits(rng, 1));
            a_now  = a_left && (a_dly == 0);
            a_read_ack <= a_now;
            b_read_ack <= 1'b0;
            if (a_now) begin
                a_read_port <= a_port;
                rd[cur_a_bank][a_port] = cur_a;
            end else if (a_left) begin
                a_dly--;
            end
            if (b_left && b_dly == 0) begin
                // Both acks on one bank must use different ports
                if (a_now && cur_a_bank == cur_b_bank) begin
                    b_port = !a_port;
                end
                b_read_ack  <= 1'b1;
                b_read_port <= b_port;
                rd[cur_b_bank][b_port] = cur_b;
            end else if (b_left) begin
                b_dly--;
            end
            read_data <= rd;
            wb_ready  <= (lfsr_bits(rng, 2) != 0);

            if (!presenting && issued < NUM_OPS && lfsr_bits(rng, 2) != 0) begin
                gen_op(nxt_op, nxt_a, nxt_b, nxt_exp);
                issue_valid  <= 1'b1;
                issue        <= nxt_op;
                issue_a_bank <= 2'(lfsr_bits(rng, 2));
                issue_b_bank <= 2'(lfsr_bits(rng, 2));
                presenting = 1'b1;
                issued++;
            end
        end

        // Drain the pipeline
        idle = 0;
        while (expect_q.size() != 0 && !timed_out) begin
            @(posedge CLK);
            wb_ready <= (lfsr_bits(rng, 2) != 0);
            idle++;
            if (idle > TIMEOUT) begin
                $display("timeout: %0d results never retired", expect_q.size());
                timed_out = 1'b1;
            end
        end
        // A few idle edges so stray results are seen
        wb_ready <= 1'b1;
        repeat (8) @(posedge CLK);

        $display("errors: %0d wrong values, %0d unexpected results, %0d results checked",
                 value_errors, unexpected_results, checked);
        if (timed_out || value_errors != 0 || unexpected_results != 0) begin
            $display("sim failed");
        end else begin
            $display("sim passed");
        end
        $finish;
    end

    // ------------------------------------------------------------------------
    // Scoreboard, one expected entry per retiring result

    always @(posedge CLK) begin : compare
        bru_expect_t e;
        if (nRST && !(wb_valid && !wb_ready) && (wb_valid || restart_valid)) begin
            if (expect_q.size() == 0) begin
                $display("result retired with no op outstanding");
                unexpected_results++;
            end else begin
                e = expect_q.pop_front();
                checked++;
                check_flag("wb_valid", wb_valid, e.wb_valid);
                check_flag("restart_valid", restart_valid, e.restart_valid);
                if (e.wb_valid) begin
                    check_wb(wb, e.wb);
                end
                if (e.restart_valid) begin
                    check_restart(restart, e.restart);
                end
            end
        end
    end

endmodule

// ==== sim.f ====
+incdir+include
verilog/bru_pkg.sv
verilog/bru_operand_collect.sv
verilog/bru_execute.sv
verilog/bru_result_reg.sv
verilog/bru_pipeline.sv
bench/tb_bru_pipeline.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the BRU testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module tb_bru_pipeline -o tb_bru_pipeline \
    && ./obj_dir/tb_bru_pipeline | tee /dev/stderr | grep -x "sim passed" > /dev/null \
    && echo "simulation run OK" \
    || { echo "simulation run FAILED"; exit 1; }
